// File: Bender.yml
package:
  name: fetch_frontend

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fetch_pkg.sv
      - fetch/fetch_ctrl.sv
      - fetch/fetch_addr_counter.sv
      - fetch/fetch_queue.sv
      - fetch/fetch_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_clk_gen.sv
      - test/tb_fetch.sv

// File: all.f
+incdir+common
common/fetch_pkg.sv
fetch/fetch_ctrl.sv
fetch/fetch_addr_counter.sv
fetch/fetch_queue.sv
fetch/fetch_top.sv
test/tb_clk_gen.sv
test/tb_fetch.sv

// File: common/fetch_defines.svh
// fetch unit constants
// reset address, instruction queue depth and the nop shown on reset
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

//////////////////////////////
// reset state
//////////////////////////////

// first address fetched after reset
`define FETCH_START_ADDR 32'h0000_0100

// addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

//////////////////////////////
// instruction queue
//////////////////////////////

// power of two, 2 to 8
`define FETCH_IQUEUE_DEPTH 4

`endif

// File: common/fetch_pkg.sv
// fetch unit package
// shared types for the fetch front end, sized from the defines header
`include "fetch_defines.svh"

package fetch_pkg;

    // byte address and raw 32-bit instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;

    // ring buffer pointer into the instruction queue
    typedef logic [$clog2(`FETCH_IQUEUE_DEPTH)-1:0] qptr_t;

    // fill level, one bit wider so a full queue fits
    typedef logic [$clog2(`FETCH_IQUEUE_DEPTH):0] qcount_t;

    // fetch fsm
    // flush lasts one cycle after a redirect and drops the stale response
    // run streams words normally
    // full holds the request address until a pop frees room
    typedef enum logic [1:0] {
        FETCH_FLUSH,
        FETCH_RUN,
        FETCH_FULL
    } fetch_state_e;

endpackage

// File: fetch/fetch_addr_counter.sv
// fetch address counter
// steps the request address by one word, loads redirect targets and
// remembers the address of the request in flight
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_addr_counter (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             advance_i,
    input  logic             busy_i,
    input  logic             jump_i,
    input  logic             ctx_switch_i,
    input  fetch_pkg::addr_t jump_target_i,
    input  fetch_pkg::addr_t ctx_switch_target_i,
    output fetch_pkg::addr_t req_addr_o,
    output fetch_pkg::addr_t resp_addr_o
);

    fetch_pkg::addr_t req_addr;
    fetch_pkg::addr_t resp_addr;
    fetch_pkg::addr_t next_addr;
    fetch_pkg::addr_t target;
    logic             accept;

    //////////////////////////////
    // target select
    //////////////////////////////

    // context switch wins over jump and both are forced to a word boundary
    always_comb begin
        if (ctx_switch_i) begin
            target = {ctx_switch_target_i[31:2], 2'b00};
        end else begin
            target = {jump_target_i[31:2], 2'b00};
        end
    end

    assign next_addr = req_addr + 32'd4;

    // memory takes the request only when not busy
    assign accept = advance_i && !busy_i;

    //////////////////////////////
    // address registers
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req_addr <= `FETCH_START_ADDR;
        end else if (jump_i || ctx_switch_i) begin
            req_addr <= target;
        end else if (accept) begin
            req_addr <= next_addr;
        end
    end

    // pc of the word that memory returns next cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            resp_addr <= `FETCH_START_ADDR;
        end else if (accept) begin
            resp_addr <= req_addr;
        end
    end

    // low bits stay zero since start address and targets are aligned
    assign req_addr_o  = req_addr;
    assign resp_addr_o = resp_addr;

endmodule

// File: fetch/fetch_ctrl.sv
// fetch control FSM
// decides flush, push, pop, bypass and address advance each cycle
// from memory busy, decode enable, redirects and the queue level
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_ctrl (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              enable_i,
    input  logic              jump_i,
    input  logic              ctx_switch_i,
    input  logic              busy_i,
    input  fetch_pkg::qcount_t q_count_i,
    input  logic              q_not_empty_i,
    output logic              flush_o,
    output logic              push_o,
    output logic              pop_o,
    output logic              advance_o,
    output logic              bypass_o,
    output logic              jumping_o
);

    fetch_pkg::fetch_state_e state_q;
    fetch_pkg::fetch_state_e state_d;
    // memory busy in the previous cycle
    logic                    busy_r;
    logic                    redirect;
    logic                    resp_valid;
    logic                    head_pop;
    logic                    deliver;
    fetch_pkg::qcount_t      next_count;
    logic                    full_next;

    //////////////////////////////
    // response and queue decisions
    //////////////////////////////

    assign redirect = jump_i || ctx_switch_i;
    assign flush_o  = redirect;

    // word on the bus is real only in run after a cycle without busy
    // flush and full both follow a cycle that sent no new request
    assign resp_valid = !busy_r && !redirect && (state_q == fetch_pkg::FETCH_RUN);

    // decode consumes whenever enabled, except in the redirect cycle
    assign pop_o = enable_i && !redirect;

    // empty queue and decode ready means the memory word goes straight out
    assign bypass_o = pop_o && !q_not_empty_i && resp_valid;
    assign push_o   = resp_valid && !bypass_o;

    assign head_pop = pop_o && q_not_empty_i;
    assign deliver  = head_pop || bypass_o;

    // a new request needs a free slot in the level after this cycle
    assign next_count = q_count_i + fetch_pkg::qcount_t'(push_o)
                        - fetch_pkg::qcount_t'(head_pop);
    assign full_next  = !(next_count < fetch_pkg::qcount_t'(`FETCH_IQUEUE_DEPTH));

    // redirect loads the target in the counter, so no advance then
    assign advance_o = !redirect && !full_next;

    //////////////////////////////
    // state
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        if (redirect) begin
            state_d = fetch_pkg::FETCH_FLUSH;
        end else begin
            case (state_q)
                fetch_pkg::FETCH_FLUSH: state_d = fetch_pkg::FETCH_RUN;
                // address holds in full until a pop makes room
                fetch_pkg::FETCH_RUN,
                fetch_pkg::FETCH_FULL: begin
                    state_d = full_next ? fetch_pkg::FETCH_FULL : fetch_pkg::FETCH_RUN;
                end
                default: state_d = fetch_pkg::FETCH_FLUSH;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= fetch_pkg::FETCH_FLUSH;
        end else begin
            state_q <= state_d;
        end
    end

    // memory busy last cycle means no word arrives now
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_r <= 1'b1;
        end else begin
            busy_r <= busy_i;
        end
    end

    // high from a redirect until the first word of the new path leaves
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumping_o <= 1'b1;
        end else if (redirect) begin
            jumping_o <= 1'b1;
        end else if (deliver) begin
            jumping_o <= 1'b0;
        end
    end

endmodule

// File: fetch/fetch_queue.sv
// fetch instruction queue
// ring buffer of pc and instruction pairs with a bypass for the memory
// word, and the registered outputs toward decode
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_queue (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               flush_i,
    input  logic               push_i,
    input  logic               pop_i,
    input  logic               bypass_i,
    input  fetch_pkg::addr_t   resp_addr_i,
    input  fetch_pkg::instr_t  instr_data_i,
    output fetch_pkg::qcount_t q_count_o,
    output logic               q_not_empty_o,
    output logic               valid_o,
    output fetch_pkg::addr_t   pc_o,
    output fetch_pkg::instr_t  instruction_o
);

    // pc and instruction slots
    fetch_pkg::addr_t   pc_mem    [`FETCH_IQUEUE_DEPTH];
    fetch_pkg::instr_t  instr_mem [`FETCH_IQUEUE_DEPTH];

    fetch_pkg::qptr_t   wr_ptr;
    fetch_pkg::qptr_t   rd_ptr;
    fetch_pkg::qcount_t count;
    logic               head_pop;

    assign q_count_o     = count;
    assign q_not_empty_o = (count != '0);

    // on bypass the memory word goes out and the queue head stays put
    assign head_pop = pop_i && !bypass_i && q_not_empty_o;

    //////////////////////////////
    // pointers and fill level
    //////////////////////////////

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (head_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + fetch_pkg::qcount_t'(push_i)
                     - fetch_pkg::qcount_t'(head_pop);
        end
    end

    // write slot
    always_ff @(posedge clk) begin
        if (push_i && !flush_i) begin
            pc_mem[wr_ptr]    <= resp_addr_i;
            instr_mem[wr_ptr] <= instr_data_i;
        end
    end

    //////////////////////////////
    // decode side outputs
    //////////////////////////////

    // outputs only move on pop, so they hold while decode stalls
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o          <= `FETCH_START_ADDR;
            instruction_o <= `FETCH_NOP;
        end else if (pop_i && !flush_i) begin
            if (bypass_i) begin
                pc_o          <= resp_addr_i;
                instruction_o <= instr_data_i;
            end else if (q_not_empty_o) begin
                pc_o          <= pc_mem[rd_ptr];
                instruction_o <= instr_mem[rd_ptr];
            end
        end
    end

    // nothing to hand over means decode sees a bubble
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (pop_i) begin
            valid_o <= bypass_i || q_not_empty_o;
        end
    end

endmodule

// File: fetch/fetch_top.sv
// instruction fetch front end
// requests words from a stalling memory, buffers them and hands one
// pc and instruction per cycle to decode, redirects flush the path
`timescale 1ns/1ps

module fetch_top (
    input  logic              clk,
    input  logic              reset_n,
    // decode side
    input  logic              enable_i,
    input  logic              jump_i,
    input  fetch_pkg::addr_t  jump_target_i,
    input  logic              ctx_switch_i,
    input  fetch_pkg::addr_t  ctx_switch_target_i,
    // memory side
    input  logic              busy_i,
    input  fetch_pkg::instr_t instr_data_i,
    output fetch_pkg::addr_t  instr_addr_o,
    // toward decode
    output fetch_pkg::addr_t  pc_o,
    output fetch_pkg::instr_t instruction_o,
    output logic              valid_o,
    output logic              jumping_o
);

    logic               flush;
    logic               push;
    logic               pop;
    logic               advance;
    logic               bypass;
    fetch_pkg::qcount_t q_count;
    logic               q_not_empty;
    fetch_pkg::addr_t   resp_addr;

    //////////////////////////////
    // control and address
    //////////////////////////////

    fetch_ctrl ctrl_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .enable_i     (enable_i),
        .jump_i       (jump_i),
        .ctx_switch_i (ctx_switch_i),
        .busy_i       (busy_i),
        .q_count_i    (q_count),
        .q_not_empty_i(q_not_empty),
        .flush_o      (flush),
        .push_o       (push),
        .pop_o        (pop),
        .advance_o    (advance),
        .bypass_o     (bypass),
        .jumping_o    (jumping_o)
    );

    fetch_addr_counter addr_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .advance_i          (advance),
        .busy_i             (busy_i),
        .jump_i             (jump_i),
        .ctx_switch_i       (ctx_switch_i),
        .jump_target_i      (jump_target_i),
        .ctx_switch_target_i(ctx_switch_target_i),
        .req_addr_o         (instr_addr_o),
        .resp_addr_o        (resp_addr)
    );

    // queue datapath
    fetch_queue queue_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .flush_i      (flush),
        .push_i       (push),
        .pop_i        (pop),
        .bypass_i     (bypass),
        .resp_addr_i  (resp_addr),
        .instr_data_i (instr_data_i),
        .q_count_o    (q_count),
        .q_not_empty_o(q_not_empty),
        .valid_o      (valid_o),
        .pc_o         (pc_o),
        .instruction_o(instruction_o)
    );

endmodule

// File: test/tb_clk_gen.sv
// testbench clock and reset source
// 4 ns clock, reset_n held low for the first 10 rising edges
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic reset_n_o
);

    // 250 MHz
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // release shortly after an edge, like the other stimulus
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_n_o = 1'b1;
    end

endmodule

// File: test/tb_fetch.sv
// fetch front end testbench
// stalling memory model, table of stream, hold and redirect tests,
// pc and instruction checks against a running expected pc
`timescale 1ns/1ps
`include "fetch_defines.svh"

module tb_fetch;

    localparam int DRIVE_DELAY   = 1;
    localparam int TEST_TIMEOUT  = 400;
    localparam int RESET_TIMEOUT = 50;
    localparam int MAX_TESTS     = 16;
    // redirect kinds in the table
    localparam int REDIR_NONE = 0;
    localparam int REDIR_JUMP = 1;
    localparam int REDIR_CTX  = 2;
    localparam int REDIR_BOTH = 3;

    logic              clk;
    logic              reset_n;
    logic              enable_i;
    logic              jump_i;
    logic              ctx_switch_i;
    logic              busy_i;
    logic              valid_o;
    logic              jumping_o;
    fetch_pkg::addr_t  jump_target_i;
    fetch_pkg::addr_t  ctx_switch_target_i;
    fetch_pkg::addr_t  instr_addr_o;
    fetch_pkg::addr_t  pc_o;
    fetch_pkg::instr_t instr_data_i;
    fetch_pkg::instr_t instruction_o;

    // memory model state
    logic              mem_req;
    fetch_pkg::addr_t  mem_addr;
    logic              stall_en;
    integer            seed;

    // stimulus table with one entry per test
    string             t_name        [MAX_TESTS];
    logic              t_stall       [MAX_TESTS];
    int                t_low_start   [MAX_TESTS];
    int                t_low_len     [MAX_TESTS];
    int                t_redir       [MAX_TESTS];
    fetch_pkg::addr_t  t_target      [MAX_TESTS];
    int                t_redir_cycle [MAX_TESTS];
    int                t_count       [MAX_TESTS];
    int                num_tests;

    // scoreboard
    fetch_pkg::addr_t  expected_pc;
    string             cur_test;
    int                mismatches;
    int                tests_passed;
    int                tests_failed;
    logic              timed_out;

    tb_clk_gen clk_gen_i (
        .clk_o    (clk),
        .reset_n_o(reset_n)
    );

    fetch_top dut_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .enable_i           (enable_i),
        .jump_i             (jump_i),
        .jump_target_i      (jump_target_i),
        .ctx_switch_i       (ctx_switch_i),
        .ctx_switch_target_i(ctx_switch_target_i),
        .busy_i             (busy_i),
        .instr_data_i       (instr_data_i),
        .instr_addr_o       (instr_addr_o),
        .pc_o               (pc_o),
        .instruction_o      (instruction_o),
        .valid_o            (valid_o),
        .jumping_o          (jumping_o)
    );

    //////////////////////////////
    // memory model
    //////////////////////////////

    // request taken when busy_i is low
    // the word one cycle later is the inverted address, else a garbage pattern
    always begin
        @(negedge clk);
        mem_req  = !busy_i;
        mem_addr = instr_addr_o;
        @(posedge clk);
        #DRIVE_DELAY;
        instr_data_i = mem_req ? ~mem_addr : 32'hdead_beef;
        // about one busy cycle in four while stalling
        busy_i = stall_en && (($random(seed) & 3) == 0);
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_addr(input string what, input fetch_pkg::addr_t exp,
                              input fetch_pkg::addr_t act);
        if (exp !== act) begin
            mismatches++;
            $display("mismatch test %s %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_instr(input string what, input fetch_pkg::instr_t exp,
                               input fetch_pkg::instr_t act);
        if (exp !== act) begin
            mismatches++;
            $display("mismatch test %s %s expected %h actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            mismatches++;
            $display("mismatch test %s %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    //////////////////////////////
    // table
    //////////////////////////////

    task automatic add_test(input string name, input logic stall, input int low_start,
                            input int low_len, input int redir,
                            input fetch_pkg::addr_t target, input int redir_cycle,
                            input int count);
        t_name[num_tests]        = name;
        t_stall[num_tests]       = stall;
        t_low_start[num_tests]   = low_start;
        t_low_len[num_tests]     = low_len;
        t_redir[num_tests]       = redir;
        t_target[num_tests]      = target;
        t_redir_cycle[num_tests] = redir_cycle;
        t_count[num_tests]       = count;
        num_tests++;
    endtask

    // name, stall, enable low start and length, redirect, target, cycle, count
    task automatic load_table();
        add_test("stream_no_stall",    1'b0, 0, 0,  REDIR_NONE, 32'h0,         0, 10);
        add_test("stream_random_busy", 1'b1, 0, 0,  REDIR_NONE, 32'h0,         0, 24);
        add_test("decode_hold",        1'b0, 2, 10, REDIR_NONE, 32'h0,         0, 12);
        add_test("hold_random_busy",   1'b1, 3, 8,  REDIR_NONE, 32'h0,         0, 12);
        add_test("jump_unaligned",     1'b0, 0, 0,  REDIR_JUMP, 32'h0000_2006, 4, 8);
        add_test("jump_random_busy",   1'b1, 0, 0,  REDIR_JUMP, 32'h0000_3000, 2, 12);
        add_test("ctx_and_jump",       1'b0, 0, 0,  REDIR_BOTH, 32'h0000_8040, 3, 6);
        add_test("ctx_switch_busy",    1'b1, 0, 0,  REDIR_CTX,  32'h0001_0002, 5, 10);
    endtask

    //////////////////////////////
    // test sequencing
    //////////////////////////////

    task automatic close_test(input int errs_before, input int checked);
        if (mismatches != errs_before) begin
            tests_failed++;
            $display("test %s: fail, %0d mismatches", cur_test, mismatches - errs_before);
        end else begin
            tests_passed++;
            $display("test %s: pass, %0d instructions checked", cur_test, checked);
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (reset_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (reset_n !== 1'b1) begin
            $display("reset_n was still low after %0d cycles", RESET_TIMEOUT);
            timed_out = 1'b1;
            tests_failed++;
        end
    endtask

    // decode outputs right after reset before anything is popped
    task automatic check_reset_state();
        int errs_before;
        errs_before = mismatches;
        cur_test    = "reset_values";
        @(negedge clk);
        check_bit("valid_o", 1'b0, valid_o);
        check_bit("jumping_o", 1'b1, jumping_o);
        check_addr("pc_o", `FETCH_START_ADDR, pc_o);
        check_instr("instruction_o", `FETCH_NOP, instruction_o);
        close_test(errs_before, 0);
    endtask

    task automatic run_test(input int idx);
        int                cycle;
        int                collected;
        int                errs_before;
        logic              redirect_done;
        logic              redirect_now;
        logic              redirect_prev;
        logic              en;
        logic              prev_hold;
        fetch_pkg::addr_t  hold_pc;
        fetch_pkg::instr_t hold_instr;
        logic              hold_valid;
        cur_test      = t_name[idx];
        errs_before   = mismatches;
        stall_en      = t_stall[idx];
        redirect_done = (t_redir[idx] == REDIR_NONE);
        redirect_prev = 1'b0;
        prev_hold     = 1'b0;
        cycle         = 0;
        collected     = 0;
        while (!(redirect_done && collected >= t_count[idx])) begin
            if (cycle >= TEST_TIMEOUT) begin
                $display("timeout in test %s, only %0d of %0d instructions arrived in %0d cycles",
                         cur_test, collected, t_count[idx], TEST_TIMEOUT);
                timed_out = 1'b1;
                tests_failed++;
                break;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            en           = !(cycle >= t_low_start[idx] &&
                             cycle < t_low_start[idx] + t_low_len[idx]);
            redirect_now = (t_redir[idx] != REDIR_NONE) && (cycle == t_redir_cycle[idx]);
            enable_i     = en;
            jump_i       = 1'b0;
            ctx_switch_i = 1'b0;
            if (redirect_now) begin
                // the losing target is a decoy that must never show up
                jump_target_i       = t_target[idx] + 32'h0000_4000;
                ctx_switch_target_i = t_target[idx] + 32'h0000_8000;
                if (t_redir[idx] == REDIR_JUMP) begin
                    jump_i        = 1'b1;
                    jump_target_i = t_target[idx];
                end else begin
                    ctx_switch_i        = 1'b1;
                    jump_i              = (t_redir[idx] == REDIR_BOTH);
                    ctx_switch_target_i = t_target[idx];
                end
            end
            @(negedge clk);
            // nothing may move after a cycle with decode stalled
            if (prev_hold) begin
                check_addr("pc_o held", hold_pc, pc_o);
                check_instr("instruction_o held", hold_instr, instruction_o);
                check_bit("valid_o held", hold_valid, valid_o);
            end
            if (jumping_o === 1'b1) begin
                check_bit("valid_o while jumping_o", 1'b0, valid_o);
            end
            // memory only ever sees word addresses
            check_bit("instr_addr_o low bits", 1'b0, |instr_addr_o[1:0]);
            if (redirect_prev) begin
                // target already on the memory bus, delivery still pending
                check_addr("instr_addr_o after redirect", {t_target[idx][31:2], 2'b00},
                           instr_addr_o);
                check_bit("jumping_o after redirect", 1'b1, jumping_o);
            end
            if (en && valid_o === 1'b1) begin
                check_addr("pc_o", expected_pc, pc_o);
                check_instr("instruction_o", ~expected_pc, instruction_o);
                check_bit("jumping_o", 1'b0, jumping_o);
                expected_pc = expected_pc + 32'd4;
                collected++;
            end
            if (redirect_now) begin
                // new path starts at the aligned target
                expected_pc   = {t_target[idx][31:2], 2'b00};
                collected     = 0;
                redirect_done = 1'b1;
            end
            redirect_prev = redirect_now;
            prev_hold     = !en && !redirect_now;
            hold_pc       = pc_o;
            hold_instr    = instruction_o;
            hold_valid    = valid_o;
            cycle++;
        end
        if (!timed_out) begin
            close_test(errs_before, collected);
        end
    endtask

    //////////////////////////////
    // main
    //////////////////////////////

    initial begin
        enable_i            = 1'b0;
        jump_i              = 1'b0;
        ctx_switch_i        = 1'b0;
        jump_target_i       = '0;
        ctx_switch_target_i = '0;
        busy_i              = 1'b0;
        instr_data_i        = '0;
        mem_req             = 1'b0;
        mem_addr            = '0;
        stall_en            = 1'b0;
        seed                = 29;
        num_tests           = 0;
        mismatches          = 0;
        tests_passed        = 0;
        tests_failed        = 0;
        timed_out           = 1'b0;
        expected_pc         = `FETCH_START_ADDR;
        cur_test            = "reset_values";
        load_table();
        wait_reset();
        if (!timed_out) begin
            check_reset_state();
            for (int i = 0; i < num_tests; i++) begin
                if (!timed_out) begin
                    run_test(i);
                end
            end
        end
        $display("tests passed %0d, failed %0d, mismatches %0d",
                 tests_passed, tests_failed, mismatches);
        if (tests_failed == 0 && mismatches == 0 && !timed_out) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
